//--- body_rate_ctrl.sv
module body_rate_ctrl (
	input  logic       start_signal,
	input  logic       resetn,
	input  logic       cycle_start,
	input  logic [2:0] pid_busy,
	input  logic [2:0] pid_done,
	output logic       pid_start,
	output logic       complete
);
	import flight_pkg::*;

	seq_state_e state, next_state;
	// sticky per-axis done flags
	logic [2:0] done_mask;

	always_ff @(posedge start_signal or negedge resetn) begin
		if (!resetn)
			state <= SEQ_WAIT;
		else
			state <= next_state;
	end

	always_comb begin
		next_state = state;
		case (state)
			// requests outside this state are dropped
			SEQ_WAIT: if (cycle_start) next_state = SEQ_START;
			SEQ_START: next_state = SEQ_ACTIVE;
			SEQ_ACTIVE: if ((done_mask | pid_done) == 3'b111) next_state = SEQ_DONE;
			SEQ_DONE: next_state = SEQ_WAIT;
			default: next_state = SEQ_WAIT;
		endcase
	end

	always_ff @(posedge start_signal or negedge resetn) begin
		if (!resetn)
			done_mask <= '0;
		else if (state == SEQ_START)
			done_mask <= '0;
		else if (state == SEQ_ACTIVE)
			done_mask <= done_mask | pid_done;
	end

	// moore outputs, one cycle each
	assign pid_start = (state == SEQ_START);
	assign complete = (state == SEQ_DONE);

	// units have all returned to idle before the next start
	a_start_when_idle: assert property (@(posedge start_signal) disable iff (!resetn)
		pid_start |-> (pid_busy == 3'b000));

endmodule

//--- files.f
flight_pkg.sv
gain_regs.sv
mul_arbiter.sv
rate_pid.sv
body_rate_ctrl.sv
rate_ctrl_top.sv
tb_rate_ctrl.sv

//--- flight_pkg.sv
package flight_pkg;

	// rate and gain width, Q12.4
	localparam int RATE_W = 16;
	localparam int FRAC_BITS = 4;
	// products and integral
	localparam int ACC_W = 32;
	// AXI4-Lite byte address width, covers the 0x00..0x20 map
	localparam int AXI_ADDR_W = 8;

	// one axis worth of gains
	typedef struct packed {
		logic signed [RATE_W-1:0] kp;
		logic signed [RATE_W-1:0] ki;
		logic signed [RATE_W-1:0] kd;
	} gains_t;

	// all three axes, 144 bits
	typedef struct packed {
		gains_t roll;
		gains_t pitch;
		gains_t yaw;
	} gain_set_t;

	// multiplier request, operands held until granted
	typedef struct packed {
		logic valid;
		logic signed [RATE_W-1:0] a;
		logic signed [RATE_W-1:0] b;
	} mul_req_t;

	// multiplier response, one cycle after grant
	typedef struct packed {
		logic valid;
		logic signed [ACC_W-1:0] p;
	} mul_rsp_t;

	typedef enum logic [1:0] {AXIS_ROLL, AXIS_PITCH, AXIS_YAW} axis_e;

	typedef enum logic [1:0] {SEQ_WAIT, SEQ_START, SEQ_ACTIVE, SEQ_DONE} seq_state_e;

	typedef enum logic [2:0] {
		PID_IDLE, PID_MUL_P, PID_MUL_I, PID_MUL_D, PID_SUM
	} pid_state_e;

endpackage

//--- gain_regs.sv
module gain_regs #(
	parameter int rate_w = flight_pkg::RATE_W
) (
	input  logic                            start_signal,
	input  logic                            resetn,
	input  logic [flight_pkg::AXI_ADDR_W-1:0] awaddr,
	input  logic                            awvalid,
	output logic                            awready,
	input  logic [31:0]                     wdata,
	input  logic [3:0]                      wstrb,
	input  logic                            wvalid,
	output logic                            wready,
	output logic [1:0]                      bresp,
	output logic                            bvalid,
	input  logic                            bready,
	input  logic [flight_pkg::AXI_ADDR_W-1:0] araddr,
	input  logic                            arvalid,
	output logic                            arready,
	output logic [31:0]                     rdata,
	output logic [1:0]                      rresp,
	output logic                            rvalid,
	input  logic                            rready,
	output flight_pkg::gain_set_t           gains
);
	import flight_pkg::*;

	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;
	// gain slot within an axis
	localparam int G_P = 0;
	localparam int G_I = 1;
	localparam int G_D = 2;

	logic [rate_w-1:0] gain_mem [3][3];
	logic wr_accept, rd_accept;
	logic [AXI_ADDR_W-3:0] wr_word, rd_word;
	logic wr_mapped, rd_mapped;

	// word index 3*axis + gain
	function automatic axis_e word_axis(input logic [AXI_ADDR_W-3:0] w);
		if (w < 3)
			return AXIS_ROLL;
		else if (w < 6)
			return AXIS_PITCH;
		return AXIS_YAW;
	endfunction

	function automatic logic [1:0] word_gain(input logic [AXI_ADDR_W-3:0] w);
		return 2'(int'(w) - 3 * int'(word_axis(w)));
	endfunction

	// take AW and W together, only once the previous response has drained
	assign wr_accept = awvalid && wvalid && !bvalid;
	assign rd_accept = arvalid && !rvalid;
	assign awready = wr_accept;
	assign wready = wr_accept;
	assign arready = rd_accept;

	assign wr_word = awaddr[AXI_ADDR_W-1:2];
	assign rd_word = araddr[AXI_ADDR_W-1:2];
	// nine words, 0x00..0x20
	assign wr_mapped = (wr_word <= 8);
	assign rd_mapped = (rd_word <= 8);

	always_ff @(posedge start_signal or negedge resetn) begin
		if (!resetn) begin
			bvalid <= 1'b0;
			bresp <= RESP_OKAY;
			for (int a = 0; a < 3; a++)
				for (int g = 0; g < 3; g++)
					gain_mem[a][g] <= '0;
		end else if (wr_accept) begin
			bvalid <= 1'b1;
			bresp <= wr_mapped ? RESP_OKAY : RESP_SLVERR;
			if (wr_mapped) begin
				// only the two low byte lanes carry a gain
				if (wstrb[0])
					gain_mem[word_axis(wr_word)][word_gain(wr_word)][7:0] <= wdata[7:0];
				if (wstrb[1])
					gain_mem[word_axis(wr_word)][word_gain(wr_word)][rate_w-1:8] <=
						wdata[rate_w-1:8];
			end
		end else if (bready) begin
			bvalid <= 1'b0;
		end
	end

	always_ff @(posedge start_signal or negedge resetn) begin
		if (!resetn) begin
			rvalid <= 1'b0;
			rresp <= RESP_OKAY;
		end else if (rd_accept) begin
			rvalid <= 1'b1;
			rresp <= rd_mapped ? RESP_OKAY : RESP_SLVERR;
		end else if (rready) begin
			rvalid <= 1'b0;
		end
	end

	// read data, zero for unmapped words
	always_ff @(posedge start_signal) begin
		if (rd_accept)
			rdata <= rd_mapped ?
				{{(32 - rate_w){1'b0}}, gain_mem[word_axis(rd_word)][word_gain(rd_word)]} : '0;
	end

	// struct view for the PID units
	always_comb begin
		gains.roll = '{gain_mem[AXIS_ROLL][G_P], gain_mem[AXIS_ROLL][G_I],
			gain_mem[AXIS_ROLL][G_D]};
		gains.pitch = '{gain_mem[AXIS_PITCH][G_P], gain_mem[AXIS_PITCH][G_I],
			gain_mem[AXIS_PITCH][G_D]};
		gains.yaw = '{gain_mem[AXIS_YAW][G_P], gain_mem[AXIS_YAW][G_I],
			gain_mem[AXIS_YAW][G_D]};
	end

	// a write response only ever follows an accepted AW/W pair
	a_bvalid_after_write: assert property (@(posedge start_signal) disable iff (!resetn)
		$rose(bvalid) |-> $past(wr_accept));

endmodule

//--- mul_arbiter.sv
module mul_arbiter #(
	parameter int rate_w = flight_pkg::RATE_W
) (
	input  logic                 start_signal,
	input  logic                 resetn,
	input  flight_pkg::mul_req_t req [3],
	output logic [2:0]           grant,
	output flight_pkg::mul_rsp_t rsp [3]
);
	import flight_pkg::*;

	// last granted axis, rotation starts after it
	axis_e last_q;
	logic [1:0] sel;
	logic signed [rate_w-1:0] op_a, op_b;
	logic signed [2*rate_w-1:0] prod_q;
	logic [2:0] rsp_vld_q;

	// round robin pick
	always_comb begin
		int idx;
		grant = '0;
		sel = last_q;
		for (int k = 1; k <= 3; k++) begin
			idx = (int'(last_q) + k) % 3;
			if (grant == '0 && req[idx].valid) begin
				grant[idx] = 1'b1;
				sel = 2'(idx);
			end
		end
	end

	// operands of the winner
	assign op_a = req[sel].a;
	assign op_b = req[sel].b;

	always_ff @(posedge start_signal or negedge resetn) begin
		if (!resetn) begin
			last_q <= AXIS_YAW;
			rsp_vld_q <= '0;
		end else begin
			rsp_vld_q <= grant;
			if (|grant)
				last_q <= axis_e'(sel);
		end
	end

	// single shared multiplier, one register stage
	always_ff @(posedge start_signal) begin
		prod_q <= op_a * op_b;
	end

	// product broadcast, valid to the granted unit only
	always_comb begin
		for (int k = 0; k < 3; k++) begin
			rsp[k].valid = rsp_vld_q[k];
			rsp[k].p = ACC_W'(prod_q);
		end
	end

	a_grant_onehot: assert property (@(posedge start_signal) disable iff (!resetn)
		$onehot0(grant));

endmodule

//--- rate_ctrl_top.sv
module rate_ctrl_top #(
	parameter int rate_w = flight_pkg::RATE_W
) (
	input  logic                              start_signal,
	input  logic                              resetn,
	input  logic [flight_pkg::AXI_ADDR_W-1:0] awaddr,
	input  logic                              awvalid,
	output logic                              awready,
	input  logic [31:0]                       wdata,
	input  logic [3:0]                        wstrb,
	input  logic                              wvalid,
	output logic                              wready,
	output logic [1:0]                        bresp,
	output logic                              bvalid,
	input  logic                              bready,
	input  logic [flight_pkg::AXI_ADDR_W-1:0] araddr,
	input  logic                              arvalid,
	output logic                              arready,
	output logic [31:0]                       rdata,
	output logic [1:0]                        rresp,
	output logic                              rvalid,
	input  logic                              rready,
	input  logic                              cycle_start,
	input  logic signed [rate_w-1:0]          roll_target,
	input  logic signed [rate_w-1:0]          pitch_target,
	input  logic signed [rate_w-1:0]          yaw_target,
	input  logic signed [rate_w-1:0]          roll_rate,
	input  logic signed [rate_w-1:0]          pitch_rate,
	input  logic signed [rate_w-1:0]          yaw_rate,
	output logic signed [rate_w-1:0]          roll_cmd,
	output logic signed [rate_w-1:0]          pitch_cmd,
	output logic signed [rate_w-1:0]          yaw_cmd,
	output logic                              complete
);
	import flight_pkg::*;

	gain_set_t gains;
	mul_req_t mul_req [3];
	mul_rsp_t mul_rsp [3];
	logic [2:0] mul_grant;
	logic [2:0] pid_busy, pid_done;
	logic pid_start;

	gain_regs #(.rate_w(rate_w)) u_gain_regs (
		.start_signal(start_signal), .resetn(resetn),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.gains(gains)
	);

	// one multiplier for all three axes
	mul_arbiter #(.rate_w(rate_w)) u_mul_arbiter (
		.start_signal(start_signal), .resetn(resetn),
		.req(mul_req), .grant(mul_grant), .rsp(mul_rsp)
	);

	body_rate_ctrl u_seq (
		.start_signal(start_signal), .resetn(resetn),
		.cycle_start(cycle_start), .pid_busy(pid_busy), .pid_done(pid_done),
		.pid_start(pid_start), .complete(complete)
	);

	// each axis takes its own gain field and arbiter slot
	rate_pid #(.rate_w(rate_w)) roll_pid (
		.start_signal(start_signal), .resetn(resetn), .pid_start(pid_start),
		.gains(gains.roll), .target(roll_target), .actual(roll_rate),
		.mul_req(mul_req[AXIS_ROLL]), .mul_grant(mul_grant[AXIS_ROLL]),
		.mul_rsp(mul_rsp[AXIS_ROLL]), .rate_cmd(roll_cmd),
		.pid_busy(pid_busy[AXIS_ROLL]), .pid_done(pid_done[AXIS_ROLL])
	);

	rate_pid #(.rate_w(rate_w)) pitch_pid (
		.start_signal(start_signal), .resetn(resetn), .pid_start(pid_start),
		.gains(gains.pitch), .target(pitch_target), .actual(pitch_rate),
		.mul_req(mul_req[AXIS_PITCH]), .mul_grant(mul_grant[AXIS_PITCH]),
		.mul_rsp(mul_rsp[AXIS_PITCH]), .rate_cmd(pitch_cmd),
		.pid_busy(pid_busy[AXIS_PITCH]), .pid_done(pid_done[AXIS_PITCH])
	);

	rate_pid #(.rate_w(rate_w)) yaw_pid (
		.start_signal(start_signal), .resetn(resetn), .pid_start(pid_start),
		.gains(gains.yaw), .target(yaw_target), .actual(yaw_rate),
		.mul_req(mul_req[AXIS_YAW]), .mul_grant(mul_grant[AXIS_YAW]),
		.mul_rsp(mul_rsp[AXIS_YAW]), .rate_cmd(yaw_cmd),
		.pid_busy(pid_busy[AXIS_YAW]), .pid_done(pid_done[AXIS_YAW])
	);

endmodule

//--- rate_pid.sv
module rate_pid #(
	parameter int rate_w = flight_pkg::RATE_W
) (
	input  logic                     start_signal,
	input  logic                     resetn,
	input  logic                     pid_start,
	input  flight_pkg::gains_t       gains,
	input  logic signed [rate_w-1:0] target,
	input  logic signed [rate_w-1:0] actual,
	output flight_pkg::mul_req_t     mul_req,
	input  logic                     mul_grant,
	input  flight_pkg::mul_rsp_t     mul_rsp,
	output logic signed [rate_w-1:0] rate_cmd,
	output logic                     pid_busy,
	output logic                     pid_done
);
	import flight_pkg::*;

	// headroom for three products
	localparam int SUM_W = ACC_W + 2;
	localparam longint RATE_MAX = (longint'(1) <<< (rate_w - 1)) - 1;
	localparam longint RATE_MIN = -(longint'(1) <<< (rate_w - 1));
	localparam longint INT_MAX = (longint'(1) <<< (ACC_W - 1)) - 1;
	localparam longint INT_MIN = -(longint'(1) <<< (ACC_W - 1));

	pid_state_e state;
	logic signed [rate_w-1:0] err_q, diff_q, prev_err_q;
	logic signed [ACC_W-1:0] integ_q, integ_next;
	logic signed [SUM_W-1:0] acc_q, integ_sum, sum_all;
	logic signed [rate_w-1:0] err_now, diff_now, integ_clip, cmd_next;

	function automatic logic signed [rate_w-1:0] sat_rate(input logic signed [SUM_W-1:0] v);
		if (v > RATE_MAX)
			return rate_w'(RATE_MAX);
		else if (v < RATE_MIN)
			return rate_w'(RATE_MIN);
		return v[rate_w-1:0];
	endfunction

	// error and difference clipped to operand width
	assign err_now = sat_rate(SUM_W'(target) - SUM_W'(actual));
	assign diff_now = sat_rate(SUM_W'(err_now) - SUM_W'(prev_err_q));

	// integral saturates at the ACC_W range
	assign integ_sum = SUM_W'(integ_q) + SUM_W'(err_now);
	always_comb begin
		if (integ_sum > INT_MAX)
			integ_next = ACC_W'(INT_MAX);
		else if (integ_sum < INT_MIN)
			integ_next = ACC_W'(INT_MIN);
		else
			integ_next = integ_sum[ACC_W-1:0];
	end
	assign integ_clip = sat_rate(SUM_W'(integ_q));

	// D product lands in the PID_SUM cycle itself
	assign sum_all = acc_q + SUM_W'(mul_rsp.p);
	assign cmd_next = sat_rate(sum_all >>> FRAC_BITS);

	// one request per multiply state, gains read live
	always_comb begin
		mul_req.valid = 1'b0;
		mul_req.a = gains.kp;
		mul_req.b = err_q;
		case (state)
			PID_MUL_P: mul_req.valid = 1'b1;
			PID_MUL_I: begin
				mul_req.valid = 1'b1;
				mul_req.a = gains.ki;
				mul_req.b = integ_clip;
			end
			PID_MUL_D: begin
				mul_req.valid = 1'b1;
				mul_req.a = gains.kd;
				mul_req.b = diff_q;
			end
			default: mul_req.valid = 1'b0;
		endcase
	end

	assign pid_busy = (state != PID_IDLE);

	always_ff @(posedge start_signal or negedge resetn) begin
		if (!resetn) begin
			state <= PID_IDLE;
			integ_q <= '0;
			prev_err_q <= '0;
			rate_cmd <= '0;
			pid_done <= 1'b0;
		end else begin
			pid_done <= 1'b0;
			case (state)
				PID_IDLE: if (pid_start) begin
					integ_q <= integ_next;
					state <= PID_MUL_P;
				end
				// stall here until granted
				PID_MUL_P: if (mul_grant) state <= PID_MUL_I;
				PID_MUL_I: if (mul_grant) state <= PID_MUL_D;
				PID_MUL_D: if (mul_grant) state <= PID_SUM;
				PID_SUM: begin
					rate_cmd <= cmd_next;
					pid_done <= 1'b1;
					prev_err_q <= err_q;
					state <= PID_IDLE;
				end
				default: state <= PID_IDLE;
			endcase
		end
	end

	// operands and running product sum
	always_ff @(posedge start_signal) begin
		if (state == PID_IDLE && pid_start) begin
			err_q <= err_now;
			diff_q <= diff_now;
			acc_q <= '0;
		end else if (mul_rsp.valid) begin
			acc_q <= sum_all;
		end
	end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the rate loop testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
	echo "cannot enter the project directory"
	exit 1
fi

verilator --binary --timing --assert -Wno-fatal -f files.f --top-module tb_rate_ctrl -o tb_rate_ctrl
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_rate_ctrl
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi
exit 0

//--- tb_rate_ctrl.sv
module tb_rate_ctrl;
	import flight_pkg::*;

	localparam int NROWS = 10;
	// per-wait limits in clock cycles
	localparam int CYCLE_LIMIT = 40;
	localparam int AXI_LIMIT = 20;
	localparam int QUIET_CYCLES = 16;
	// reset reads, unmapped accesses, then 9 writes and 9 reads per row
	localparam int AXI_OPS = 12 + NROWS * 18;
	localparam int WATCHDOG_CYCLES = NROWS * 40 + AXI_OPS * 6 + 64;
	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;
	localparam longint RATE_HI = (longint'(1) <<< (RATE_W - 1)) - 1;
	localparam longint RATE_LO = -(longint'(1) <<< (RATE_W - 1));
	localparam longint INT_HI = (longint'(1) <<< (ACC_W - 1)) - 1;
	localparam longint INT_LO = -(longint'(1) <<< (ACC_W - 1));

	// one table row with targets and measured rates per axis
	typedef struct packed {
		gain_set_t gains;
		logic signed [RATE_W-1:0] roll_t;
		logic signed [RATE_W-1:0] roll_m;
		logic signed [RATE_W-1:0] pitch_t;
		logic signed [RATE_W-1:0] pitch_m;
		logic signed [RATE_W-1:0] yaw_t;
		logic signed [RATE_W-1:0] yaw_m;
		logic rnd;
		logic extra;
	} row_t;

	logic start_signal;
	logic resetn;
	logic [AXI_ADDR_W-1:0] awaddr;
	logic awvalid;
	logic awready;
	logic [31:0] wdata;
	logic [3:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [AXI_ADDR_W-1:0] araddr;
	logic arvalid;
	logic arready;
	logic [31:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;
	logic cycle_start;
	logic signed [RATE_W-1:0] roll_target, pitch_target, yaw_target;
	logic signed [RATE_W-1:0] roll_rate, pitch_rate, yaw_rate;
	logic signed [RATE_W-1:0] roll_cmd, pitch_cmd, yaw_cmd;
	logic complete;

	row_t rows [NROWS];
	string row_name [NROWS];
	int row_count;
	// reference model state per axis
	longint m_integ [3];
	longint m_prev [3];
	int seed;
	int err_count;
	// AXI handshakes counted at the clock edge
	int aw_taken;
	int w_taken;
	int ar_taken;

	rate_ctrl_top #(.rate_w(RATE_W)) DUT (.*);

	always #5 start_signal = ~start_signal;

	// valid and ready as the DUT samples them
	always @(posedge start_signal) begin
		if (awvalid && awready)
			aw_taken <= aw_taken + 1;
		if (wvalid && wready)
			w_taken <= w_taken + 1;
		if (arvalid && arready)
			ar_taken <= ar_taken + 1;
	end

	task automatic stop_fail();
		$display("TEST FAIL");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic check_value(input string name, input longint expected, input longint actual);
		assert (actual == expected) else begin
			err_count++;
			$display("MISMATCH %s: expected %0d actual %0d", name, expected, actual);
			stop_fail();
		end
	endtask

	function automatic longint clip16(input longint v);
		if (v > RATE_HI)
			return RATE_HI;
		else if (v < RATE_LO)
			return RATE_LO;
		return v;
	endfunction

	// one control step of one axis by the PID rule
	function automatic logic signed [RATE_W-1:0] model_step(input int ax, input gains_t g,
		input longint tgt, input longint meas);
		longint err, diff, integ, sum;
		err = clip16(tgt - meas);
		integ = m_integ[ax] + err;
		if (integ > INT_HI)
			integ = INT_HI;
		else if (integ < INT_LO)
			integ = INT_LO;
		diff = clip16(err - m_prev[ax]);
		sum = longint'(g.kp) * err + longint'(g.ki) * clip16(integ) + longint'(g.kd) * diff;
		m_integ[ax] = integ;
		m_prev[ax] = err;
		return RATE_W'(clip16(sum >>> FRAC_BITS));
	endfunction

	function automatic gains_t gain3(input int kp, input int ki, input int kd);
		gains_t g;
		g.kp = RATE_W'(kp);
		g.ki = RATE_W'(ki);
		g.kd = RATE_W'(kd);
		return g;
	endfunction

	function automatic gain_set_t gset(input gains_t r, input gains_t p, input gains_t y);
		gain_set_t s;
		s.roll = r;
		s.pitch = p;
		s.yaw = y;
		return s;
	endfunction

	// gain k (P, I, D) of axis ax
	function automatic logic [RATE_W-1:0] gain_of(input gain_set_t g, input int ax, input int k);
		gains_t s;
		case (ax)
			0: s = g.roll;
			1: s = g.pitch;
			default: s = g.yaw;
		endcase
		case (k)
			0: return s.kp;
			1: return s.ki;
			default: return s.kd;
		endcase
	endfunction

	task automatic add_row(input string name, input gain_set_t g, input int rt, input int rm,
		input int pt, input int pm, input int yt, input int ym, input bit rnd, input bit extra);
		row_t r;
		r.gains = g;
		r.roll_t = RATE_W'(rt);
		r.roll_m = RATE_W'(rm);
		r.pitch_t = RATE_W'(pt);
		r.pitch_m = RATE_W'(pm);
		r.yaw_t = RATE_W'(yt);
		r.yaw_m = RATE_W'(ym);
		r.rnd = rnd;
		r.extra = extra;
		rows[row_count] = r;
		row_name[row_count] = name;
		row_count++;
	endtask

	task automatic build_table();
		gain_set_t g_p, g_pid, g_sat_a, g_sat_b;
		// Q12.4 gains where 16 stands for 1.0
		g_p = gset(gain3(16, 0, 0), gain3(40, 0, 0), gain3(-24, 0, 0));
		g_pid = gset(gain3(16, 4, 8), gain3(24, 2, 16), gain3(12, 8, -4));
		g_sat_a = gset(gain3(32767, 0, 0), gain3(32767, 0, 0), gain3(-32768, 0, 0));
		g_sat_b = gset(gain3(-32768, 0, 0), gain3(-32768, 0, 0), gain3(32767, 0, 0));
		add_row("kp_only", g_p, 160, 80, -320, 48, 1000, -200, 0, 0);
		add_row("kp_only_neg", g_p, -800, 400, 96, 960, -40, -16, 0, 0);
		add_row("pid_step_a", g_pid, 400, 100, -200, -50, 640, 0, 0, 0);
		add_row("pid_step_b", g_pid, 400, 250, -200, -150, 640, 320, 0, 0);
		add_row("pid_step_c", g_pid, 400, 420, 0, -100, 640, 600, 0, 0);
		add_row("pid_random", g_pid, 300, 0, -300, 0, 0, 0, 1, 0);
		add_row("sat_high", g_sat_a, 20000, -10000, -20000, 10000, 16000, -4000, 0, 0);
		add_row("sat_low", g_sat_b, 20000, -10000, -20000, 10000, -16000, 4000, 0, 0);
		add_row("busy_restart", g_pid, 200, 150, -100, 0, 50, 80, 0, 1);
		add_row("after_restart", g_pid, 210, 190, -60, -20, 0, 40, 0, 0);
	endtask

	task automatic axi_write(input logic [AXI_ADDR_W-1:0] addr, input logic [31:0] data,
		input logic [3:0] strb, output logic [1:0] resp);
		int n;
		int aw_before;
		int w_before;
		aw_before = aw_taken;
		w_before = w_taken;
		awaddr = addr;
		wdata = data;
		wstrb = strb;
		awvalid = 1'b1;
		wvalid = 1'b1;
		bready = 1'b1;
		n = 0;
		do begin
			@(negedge start_signal);
			n++;
			if (!bvalid && n >= AXI_LIMIT) begin
				err_count++;
				$display("no write response for address %0h", addr);
				stop_fail();
			end
		end while (!bvalid);
		resp = bresp;
		// exactly one AW and one W handshake per response
		check_value($sformatf("awready handshakes for address %0h", addr),
			aw_before + 1, aw_taken);
		check_value($sformatf("wready handshakes for address %0h", addr),
			w_before + 1, w_taken);
		awvalid = 1'b0;
		wvalid = 1'b0;
		@(negedge start_signal);
		bready = 1'b0;
	endtask

	task automatic axi_read(input logic [AXI_ADDR_W-1:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		int n;
		int ar_before;
		ar_before = ar_taken;
		araddr = addr;
		arvalid = 1'b1;
		rready = 1'b1;
		n = 0;
		do begin
			@(negedge start_signal);
			n++;
			if (!rvalid && n >= AXI_LIMIT) begin
				err_count++;
				$display("no read response for address %0h", addr);
				stop_fail();
			end
		end while (!rvalid);
		data = rdata;
		resp = rresp;
		check_value($sformatf("arready handshakes for address %0h", addr),
			ar_before + 1, ar_taken);
		arvalid = 1'b0;
		@(negedge start_signal);
		rready = 1'b0;
	endtask

	// only 16 bits are stored so the upper half of wdata is junk
	task automatic write_gains(input string nm, input gain_set_t g);
		logic [1:0] resp;
		for (int ax = 0; ax < 3; ax++) begin
			for (int k = 0; k < 3; k++) begin
				axi_write(AXI_ADDR_W'(4 * (3 * ax + k)), {16'hA5A5, gain_of(g, ax, k)}, 4'hF, resp);
				check_value($sformatf("%s bresp axis %0d gain %0d", nm, ax, k), RESP_OKAY, resp);
			end
		end
	endtask

	task automatic check_gains(input string nm, input gain_set_t g);
		logic [31:0] data;
		logic [1:0] resp;
		for (int ax = 0; ax < 3; ax++) begin
			for (int k = 0; k < 3; k++) begin
				axi_read(AXI_ADDR_W'(4 * (3 * ax + k)), data, resp);
				check_value($sformatf("%s rresp axis %0d gain %0d", nm, ax, k), RESP_OKAY, resp);
				check_value($sformatf("%s readback axis %0d gain %0d", nm, ax, k),
					{16'h0000, gain_of(g, ax, k)}, data);
			end
		end
	endtask

	// request a cycle and wait for complete
	// with extra a second request lands mid-cycle
	task automatic run_cycle(input string nm, input bit extra);
		int n;
		bit seen;
		n = 0;
		seen = 0;
		cycle_start = 1'b1;
		while (!seen) begin
			@(negedge start_signal);
			n++;
			seen = complete;
			cycle_start = extra && (n == 2);
			if (!seen && n >= CYCLE_LIMIT) begin
				err_count++;
				$display("%s: complete did not arrive within %0d cycles", nm, CYCLE_LIMIT);
				stop_fail();
			end
		end
	endtask

	task automatic apply_row(input int i);
		row_t r;
		string nm;
		logic signed [RATE_W-1:0] exp_roll, exp_pitch, exp_yaw;
		r = rows[i];
		nm = row_name[i];
		if (r.rnd) begin
			r.roll_m = RATE_W'($random(seed) % 2000);
			r.pitch_m = RATE_W'($random(seed) % 2000);
			r.yaw_m = RATE_W'($random(seed) % 2000);
		end
		write_gains(nm, r.gains);
		check_gains(nm, r.gains);
		roll_target = r.roll_t;
		roll_rate = r.roll_m;
		pitch_target = r.pitch_t;
		pitch_rate = r.pitch_m;
		yaw_target = r.yaw_t;
		yaw_rate = r.yaw_m;
		exp_roll = model_step(0, r.gains.roll, r.roll_t, r.roll_m);
		exp_pitch = model_step(1, r.gains.pitch, r.pitch_t, r.pitch_m);
		exp_yaw = model_step(2, r.gains.yaw, r.yaw_t, r.yaw_m);
		run_cycle(nm, r.extra);
		check_value({nm, " roll_cmd"}, exp_roll, roll_cmd);
		check_value({nm, " pitch_cmd"}, exp_pitch, pitch_cmd);
		check_value({nm, " yaw_cmd"}, exp_yaw, yaw_cmd);
		// complete lasts one cycle
		@(negedge start_signal);
		check_value({nm, " complete width"}, 0, complete);
		if (r.extra) begin
			repeat (QUIET_CYCLES) begin
				@(negedge start_signal);
				check_value({nm, " spurious complete"}, 0, complete);
			end
		end
	endtask

	initial begin
		logic [31:0] data;
		logic [1:0] resp;
		seed = 40435;
		err_count = 0;
		row_count = 0;
		aw_taken = 0;
		w_taken = 0;
		ar_taken = 0;
		start_signal = 1'b0;
		resetn = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		cycle_start = 1'b0;
		roll_target = '0;
		pitch_target = '0;
		yaw_target = '0;
		roll_rate = '0;
		pitch_rate = '0;
		yaw_rate = '0;
		for (int a = 0; a < 3; a++) begin
			m_integ[a] = 0;
			m_prev[a] = 0;
		end
		build_table();
		repeat (2) @(negedge start_signal);
		resetn = 1'b1;

		// state right after reset
		check_value("reset complete", 0, complete);
		check_value("reset roll_cmd", 0, roll_cmd);
		check_value("reset pitch_cmd", 0, pitch_cmd);
		check_value("reset yaw_cmd", 0, yaw_cmd);
		check_gains("reset", '0);

		// one word past the map
		axi_write(AXI_ADDR_W'(8'h24), 32'h0000_FFFF, 4'hF, resp);
		check_value("unmapped write bresp", RESP_SLVERR, resp);
		axi_read(AXI_ADDR_W'(8'h24), data, resp);
		check_value("unmapped read rresp", RESP_SLVERR, resp);
		check_value("unmapped read rdata", 0, data);
		axi_read(AXI_ADDR_W'(8'h20), data, resp);
		check_value("last word after unmapped write", 0, data);

		for (int i = 0; i < row_count; i++)
			apply_row(i);

		if (err_count == 0) begin
			$display("TEST PASS");
			$finish;
		end else begin
			stop_fail();
		end
	end

	// bounds the whole run
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge start_signal);
		err_count++;
		$display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
		stop_fail();
	end

endmodule
